// ==== common/wb_pkg.sv ====
package wb_pkg;

    localparam int XLEN       = 32;
    localparam int NUM_REGS   = 32;
    localparam int REG_ADDR_W = $clog2(NUM_REGS);
    localparam int APB_ADDR_W = 8;

    // program end address, seen as the exit point of a test program
    localparam logic [XLEN-1:0] EXIT_PC   = 32'h1000;
    localparam logic [XLEN-1:0] REG_RESET = 32'hffff_ffff;

    // last legal APB byte address, register 31
    localparam logic [APB_ADDR_W-1:0] APB_LAST_ADDR = 8'h7c;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        WB_ALU   = 4'd0,
        WB_MEMB  = 4'd1,
        WB_MEMBU = 4'd2,
        WB_MEMH  = 4'd3,
        WB_MEMHU = 4'd4,
        WB_MEMW  = 4'd5,
        WB_PC    = 4'd6,
        WB_CSR   = 4'd7
    } wb_sel_e;

    // one instruction leaving the pipe
    typedef struct packed {
        logic      valid;
        xlen_t     pc;
        wb_sel_e   wb_sel;
        xlen_t     csr_rdata;
        xlen_t     mem_rdata;
        xlen_t     alu_out;
        reg_addr_t wb_addr;
        logic      rf_wen;
        logic      br_flg;
        xlen_t     br_target;
        logic      jmp_flg;
        logic      is_ecall;
        xlen_t     trap_vector;
    } retire_t;

    typedef struct packed {
        xlen_t next_pc;
        logic  hazard;   // fetch side flushes on this
        logic  exit;
    } redirect_t;

    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        xlen_t     data;
    } rf_write_t;

endpackage

// ==== writeback/wb_data_select.sv ====
`timescale 1ns/1ps

module wb_data_select (
    input  logic               clk,
    input  logic               rst_n,
    input  wb_pkg::retire_t    retire,
    output wb_pkg::rf_write_t  wb_write
);

    wb_pkg::xlen_t pc_plus4;
    wb_pkg::xlen_t wb_data;

    assign pc_plus4 = retire.pc + wb_pkg::xlen_t'(4);

    always_comb begin
        case (retire.wb_sel)
            wb_pkg::WB_MEMB: begin
                wb_data = {{24{retire.mem_rdata[7]}}, retire.mem_rdata[7:0]};
            end
            wb_pkg::WB_MEMBU: begin
                wb_data = {24'b0, retire.mem_rdata[7:0]};
            end
            wb_pkg::WB_MEMH: begin
                wb_data = {{16{retire.mem_rdata[15]}}, retire.mem_rdata[15:0]};
            end
            wb_pkg::WB_MEMHU: begin
                wb_data = {16'b0, retire.mem_rdata[15:0]};
            end
            wb_pkg::WB_MEMW: wb_data = retire.mem_rdata;
            wb_pkg::WB_PC:   wb_data = pc_plus4;     // link address
            wb_pkg::WB_CSR:  wb_data = retire.csr_rdata;
            default:         wb_data = retire.alu_out;
        endcase
    end

    // x0 never written
    assign wb_write.en   = retire.valid && retire.rf_wen && (retire.wb_addr != '0);
    assign wb_write.addr = retire.wb_addr;
    assign wb_write.data = wb_data;

    // upstream must hand over a defined source code with every valid record
    a_wb_sel_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        retire.valid |-> !$isunknown(retire.wb_sel)
    ) else $error("wb_sel unknown on a valid retire");

endmodule

// ==== writeback/next_pc_select.sv ====
`timescale 1ns/1ps

module next_pc_select (
    input  logic               clk,
    input  logic               rst_n,
    input  wb_pkg::retire_t    retire,
    output wb_pkg::redirect_t  redirect
);

    wb_pkg::xlen_t pc_plus4;
    wb_pkg::xlen_t next_pc;

    assign pc_plus4 = retire.pc + wb_pkg::xlen_t'(4);

    // branch wins over jump, jump over ecall
    always_comb begin
        if (retire.br_flg) begin
            next_pc = retire.br_target;
        end else if (retire.jmp_flg) begin
            next_pc = retire.alu_out;       // jal/jalr target from the alu
        end else if (retire.is_ecall) begin
            next_pc = retire.trap_vector;
        end else begin
            next_pc = pc_plus4;
        end
    end

    assign redirect.next_pc = next_pc;
    assign redirect.hazard  = retire.valid
                              && (retire.br_flg || retire.jmp_flg || retire.is_ecall);
    assign redirect.exit    = retire.valid && (retire.pc == wb_pkg::EXIT_PC);

    // decode never marks an ecall as a control transfer too
    a_ecall_alone: assert property (
        @(posedge clk) disable iff (!rst_n)
        (retire.valid && retire.is_ecall) |-> !(retire.br_flg || retire.jmp_flg)
    ) else $error("ecall flagged together with branch or jump");

endmodule

// ==== logic/regfile.sv ====
`timescale 1ns/1ps

module regfile (
    input  logic                            clk,
    input  logic                            rst_n,
    input  wb_pkg::rf_write_t               wb_write,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [wb_pkg::APB_ADDR_W-1:0]   paddr,
    input  wb_pkg::xlen_t                   pwdata,
    output wb_pkg::xlen_t                   prdata,
    output logic                            pready,
    output logic                            pslverr
);

    // x0 has no storage
    wb_pkg::xlen_t regs [1:wb_pkg::NUM_REGS-1];

    logic              apb_access;
    logic              addr_bad;
    logic              apb_err;
    wb_pkg::reg_addr_t rd_idx;
    wb_pkg::xlen_t     rd_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < wb_pkg::NUM_REGS; i++) begin
                regs[i] <= wb_pkg::REG_RESET;
            end
        end else if (wb_write.en) begin
            regs[wb_write.addr] <= wb_write.data;   // en already excludes x0
        end
    end

    assign apb_access = psel && penable;

    assign addr_bad = (paddr > wb_pkg::APB_LAST_ADDR) || (paddr[1:0] != 2'b00);
    assign apb_err  = pwrite || addr_bad;   // port is read-only

    assign rd_idx = paddr[wb_pkg::REG_ADDR_W+1:2];

    // read is combinational so a same-cycle write is not yet seen
    always_comb begin
        if (rd_idx == '0) begin
            rd_data = '0;
        end else begin
            rd_data = regs[rd_idx];
        end
    end

    assign pready  = apb_access;              // never any wait states
    assign pslverr = apb_access && apb_err;
    assign prdata  = (apb_access && !apb_err) ? rd_data : '0;

    // the requester keeps the setup phase before every access phase
    a_apb_setup: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(penable) |-> $past(psel)
    ) else $error("penable rose without a setup cycle");

endmodule

// ==== writeback/writeback_stage.sv ====
`timescale 1ns/1ps

module writeback_stage (
    input  logic                            clk,
    input  logic                            rst_n,
    input  wb_pkg::retire_t                 retire,
    output wb_pkg::redirect_t               redirect,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [wb_pkg::APB_ADDR_W-1:0]   paddr,
    input  wb_pkg::xlen_t                   pwdata,
    output wb_pkg::xlen_t                   prdata,
    output logic                            pready,
    output logic                            pslverr
);

    wb_pkg::rf_write_t wb_write;

    wb_data_select u_wb_data_select (
        .clk      (clk),
        .rst_n    (rst_n),
        .retire   (retire),
        .wb_write (wb_write)
    );

    // runs beside the data path, purely combinational
    next_pc_select u_next_pc_select (
        .clk      (clk),
        .rst_n    (rst_n),
        .retire   (retire),
        .redirect (redirect)
    );

    regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_write (wb_write),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr)
    );

endmodule

// ==== tests/wb_vectors.svh ====
`ifndef WB_VECTORS_SVH
`define WB_VECTORS_SVH

// one retire record per row, and what the stage must answer
typedef struct packed {
    logic              valid;
    wb_pkg::xlen_t     pc;
    wb_pkg::wb_sel_e   sel;
    wb_pkg::xlen_t     data;       // goes to the field that sel or jmp uses
    wb_pkg::reg_addr_t addr;
    logic              wen;
    logic [2:0]        flags;      // br, jmp, ecall
    wb_pkg::xlen_t     target;     // branch target or trap vector
    wb_pkg::xlen_t     exp_pc;
    logic [2:0]        exp_flags;  // hazard, exit, write
    wb_pkg::xlen_t     exp_data;
} vector_t;

localparam int NUM_VECTORS = 18;

// columns: valid, pc, sel, data, addr, wen, flags, target
//          then exp_pc, exp_flags, exp_data
vector_t vectors [NUM_VECTORS] = '{
    '{1'b1, 32'h0000_0100, wb_pkg::WB_ALU, 32'h1234_5678, 5'd1, 1'b1, 3'b000, 32'h0000_0000,
      32'h0000_0104, 3'b001, 32'h1234_5678},
    '{1'b1, 32'h0000_0104, wb_pkg::WB_MEMB, 32'h0000_00f0, 5'd2, 1'b1, 3'b000, 32'h0000_0000,
      32'h0000_0108, 3'b001, 32'hffff_fff0},
    '{1'b1, 32'h0000_0108, wb_pkg::WB_MEMB, 32'hffff_ff70, 5'd3, 1'b1, 3'b000, 32'h0000_0000,
      32'h0000_010c, 3'b001, 32'h0000_0070},
    '{1'b1, 32'h0000_010c, wb_pkg::WB_MEMBU, 32'h0000_00a5, 5'd4, 1'b1, 3'b000, 32'h0000_0000,
      32'h0000_0110, 3'b001, 32'h0000_00a5},
    '{1'b1, 32'h0000_0110, wb_pkg::WB_MEMBU, 32'hffff_ff5a, 5'd5, 1'b1, 3'b000, 32'h0000_0000,
      32'h0000_0114, 3'b001, 32'h0000_005a},
    '{1'b1, 32'h0000_0114, wb_pkg::WB_MEMH, 32'h0000_8001, 5'd6, 1'b1, 3'b000, 32'h0000_0000,
      32'h0000_0118, 3'b001, 32'hffff_8001},
    '{1'b1, 32'h0000_0118, wb_pkg::WB_MEMH, 32'hffff_7ffe, 5'd7, 1'b1, 3'b000, 32'h0000_0000,
      32'h0000_011c, 3'b001, 32'h0000_7ffe},
    '{1'b1, 32'h0000_011c, wb_pkg::WB_MEMHU, 32'h0000_c3c3, 5'd8, 1'b1, 3'b000, 32'h0000_0000,
      32'h0000_0120, 3'b001, 32'h0000_c3c3},
    '{1'b1, 32'h0000_0120, wb_pkg::WB_MEMHU, 32'habcd_4321, 5'd9, 1'b1, 3'b000, 32'h0000_0000,
      32'h0000_0124, 3'b001, 32'h0000_4321},
    '{1'b1, 32'h0000_0124, wb_pkg::WB_MEMW, 32'h8765_4321, 5'd10, 1'b1, 3'b000, 32'h0000_0000,
      32'h0000_0128, 3'b001, 32'h8765_4321},
    '{1'b1, 32'h0000_0200, wb_pkg::WB_PC, 32'h0000_0000, 5'd11, 1'b1, 3'b000, 32'h0000_0000,
      32'h0000_0204, 3'b001, 32'h0000_0204},
    '{1'b1, 32'h0000_0204, wb_pkg::WB_CSR, 32'h0000_0b00, 5'd12, 1'b1, 3'b000, 32'h0000_0000,
      32'h0000_0208, 3'b001, 32'h0000_0b00},
    // jal style, link into x1 and jump to alu_out
    '{1'b1, 32'h0000_0300, wb_pkg::WB_PC, 32'h0000_0480, 5'd1, 1'b1, 3'b010, 32'h0000_0000,
      32'h0000_0480, 3'b101, 32'h0000_0304},
    '{1'b1, 32'h0000_0400, wb_pkg::WB_ALU, 32'h0000_0700, 5'd13, 1'b0, 3'b110, 32'h0000_0600,
      32'h0000_0600, 3'b100, 32'h0000_0000},
    '{1'b1, 32'h0000_0500, wb_pkg::WB_ALU, 32'h0000_0000, 5'd14, 1'b0, 3'b001, 32'h8000_0000,
      32'h8000_0000, 3'b100, 32'h0000_0000},
    '{1'b1, 32'h0000_0504, wb_pkg::WB_ALU, 32'hdead_beef, 5'd0, 1'b1, 3'b000, 32'h0000_0000,
      32'h0000_0508, 3'b000, 32'h0000_0000},
    // invalid record at the exit address, nothing may happen
    '{1'b0, 32'h0000_1000, wb_pkg::WB_ALU, 32'h1111_1111, 5'd2, 1'b1, 3'b100, 32'h0000_0040,
      32'h0000_0000, 3'b000, 32'h0000_0000},
    '{1'b1, 32'h0000_1000, wb_pkg::WB_MEMW, 32'h2222_2222, 5'd10, 1'b0, 3'b000, 32'h0000_0000,
      32'h0000_1004, 3'b010, 32'h0000_0000}
};

`endif

// ==== tests/tb_writeback.sv ====
`timescale 1ns/1ps

module tb_writeback;

    logic                          clk;
    logic                          rst_n;
    wb_pkg::retire_t               retire;
    wb_pkg::redirect_t             redirect;
    logic                          psel;
    logic                          penable;
    logic                          pwrite;
    logic [wb_pkg::APB_ADDR_W-1:0] paddr;
    wb_pkg::xlen_t                 pwdata;
    wb_pkg::xlen_t                 prdata;
    logic                          pready;
    logic                          pslverr;

    int unsigned   cycles = 0;
    wb_pkg::xlen_t shadow [wb_pkg::NUM_REGS];   // expected register contents

    `include "wb_vectors.svh"

    localparam int CYCLE_LIMIT = NUM_VECTORS * 8 + 100;

    writeback_stage u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .retire   (retire),
        .redirect (redirect),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("STATUS: FAIL");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    task automatic report_error(input string msg);
        $display("[ERROR] %0t %s", $time, msg);
        $display("STATUS: FAIL");
        $fatal(1, "check failed");
    endtask

    task automatic check_value(input string what, input wb_pkg::xlen_t got,
                               input wb_pkg::xlen_t exp);
        assert (got === exp) else begin
            report_error($sformatf("%s: got %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        assert (got === exp) else begin
            report_error($sformatf("%s: got %b, expected %b", what, got, exp));
        end
    endtask

    // one setup and one access cycle, then idle
    task automatic apb_transfer(input logic [wb_pkg::APB_ADDR_W-1:0] addr, input logic write,
                                output wb_pkg::xlen_t data, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= $urandom;
        @(negedge clk);
        check_bit("pready in setup", pready, 1'b0);
        check_bit("pslverr in setup", pslverr, 1'b0);
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        check_bit("pready in access", pready, 1'b1);
        data = prdata;
        err  = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic check_reg(input wb_pkg::reg_addr_t idx);
        wb_pkg::xlen_t data;
        logic          err;
        apb_transfer({1'b0, idx, 2'b00}, 1'b0, data, err);
        check_bit($sformatf("pslverr on x%0d read", idx), err, 1'b0);
        check_value($sformatf("x%0d read back", idx), data, shadow[idx]);
    endtask

    task automatic check_apb_error(input logic [wb_pkg::APB_ADDR_W-1:0] addr, input logic write);
        wb_pkg::xlen_t data;
        logic          err;
        apb_transfer(addr, write, data, err);
        check_bit($sformatf("pslverr at %h write %b", addr, write), err, 1'b1);
        check_value($sformatf("prdata at %h on error", addr), data, '0);
    endtask

    // fields the row does not care about get random data
    function automatic wb_pkg::retire_t build_record(input vector_t v);
        wb_pkg::retire_t r;
        logic            is_mem;
        is_mem = v.sel inside {wb_pkg::WB_MEMB, wb_pkg::WB_MEMBU, wb_pkg::WB_MEMH,
                               wb_pkg::WB_MEMHU, wb_pkg::WB_MEMW};
        r.valid       = v.valid;
        r.pc          = v.pc;
        r.wb_sel      = v.sel;
        r.csr_rdata   = (v.sel == wb_pkg::WB_CSR) ? v.data : $urandom;
        r.mem_rdata   = is_mem ? v.data : $urandom;
        r.alu_out     = (v.sel == wb_pkg::WB_ALU || v.flags[1]) ? v.data : $urandom;
        r.wb_addr     = v.addr;
        r.rf_wen      = v.wen;
        r.br_flg      = v.flags[2];
        r.br_target   = v.flags[2] ? v.target : $urandom;
        r.jmp_flg     = v.flags[1];
        r.is_ecall    = v.flags[0];
        r.trap_vector = v.flags[0] ? v.target : $urandom;
        return r;
    endfunction

    initial begin
        vector_t         v;
        wb_pkg::retire_t rec;
        void'($urandom(32'h7e1c_2b63));
        rst_n   = 1'b0;
        retire  = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        for (int i = 0; i < wb_pkg::NUM_REGS; i++) begin
            shadow[i] = wb_pkg::REG_RESET;
        end
        shadow[0] = '0;

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // reset contents
        check_reg(5'd1);
        check_reg(5'd17);
        check_reg(5'd31);
        check_reg(5'd0);

        check_apb_error(8'h04, 1'b1);   // port is read-only
        check_apb_error(8'h80, 1'b0);
        check_apb_error(8'h06, 1'b0);

        for (int n = 0; n < NUM_VECTORS; n++) begin
            v   = vectors[n];
            rec = build_record(v);
            @(posedge clk);
            retire <= rec;
            @(negedge clk);
            if (v.valid) begin
                check_value($sformatf("row %0d next_pc", n), redirect.next_pc, v.exp_pc);
            end
            check_bit($sformatf("row %0d hazard", n), redirect.hazard, v.exp_flags[2]);
            check_bit($sformatf("row %0d exit", n), redirect.exit, v.exp_flags[1]);
            @(posedge clk);
            retire.valid <= 1'b0;
            if (v.exp_flags[0]) begin
                shadow[v.addr] = v.exp_data;
            end
            repeat ($urandom_range(1, 0)) @(posedge clk);
            check_reg(v.addr);
        end
        check_reg(5'd0);

        repeat (2) @(posedge clk);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+tests
common/wb_pkg.sv
writeback/wb_data_select.sv
writeback/next_pc_select.sv
logic/regfile.sv
writeback/writeback_stage.sv
tests/tb_writeback.sv

// ==== Makefile ====
TOP = tb_writeback

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
